//--- logic/tcp_cfg.svh
`ifndef TCP_CFG_SVH
`define TCP_CFG_SVH

// Listening port table, the low port byte selects the row
`define TCP_PORT_BINS    256
`define TCP_PORT_WAYS    4

// Reply event queue
`define TCP_EVENT_DEPTH  32

// Header without options
`define TCP_HEADER_BYTES 20
`define TCP_HEADER_WORDS 5

`define TCP_WINDOW       1024           // Advertised window, no scaling
`define TCP_ISN          32'h0EADBEEF   // Fixed initial sequence number
`define IP_PROTO_TCP     8'd6

`define TCP_TX_CREDITS   2              // Segments the IP layer takes at reset

`endif

//--- logic/ip_bus_pkg.sv
`default_nettype none

// Types of the layer-3 bus between the IPv4 stack and TCP
package ip_bus_pkg;

	typedef logic [31:0] ipv4_addr_t;   // IPv4 address
	typedef logic [31:0] bus_word_t;    // One bus data word
	typedef logic [2:0]  bytes_valid_t; // Valid bytes in a word, 1 to 4
	typedef logic [15:0] len16_t;       // Payload length in bytes

endpackage

`default_nettype wire

//--- logic/tcp_types_pkg.sv
`default_nettype none

package tcp_types_pkg;
	import ip_bus_pkg::*;

	typedef logic [15:0] port_num_t; // Zero marks an empty table entry

	// Same order as the header flag bits, PSH left out
	typedef struct packed {
		logic ack;
		logic rst;
		logic syn;
		logic fin;
	} tcp_flags_t;

	// Header-only segment the receive side wants sent
	typedef struct packed {
		ipv4_addr_t  remote_ip;
		port_num_t   remote_port;
		port_num_t   our_port;
		tcp_flags_t  flags;
		logic [31:0] seq;
		logic [31:0] ack;
	} tcp_event_t;

	typedef enum logic [2:0] {
		RX_IDLE, RX_PORTS, RX_SEQ, RX_ACK, RX_FLAGS, RX_CSUM, RX_COMMIT
	} rx_state_t;

	typedef enum logic [2:0] {
		TX_IDLE, TX_POP, TX_PSEUDO, TX_HDR, TX_CSUM, TX_DATA, TX_COMMIT
	} tx_state_t;

endpackage

`default_nettype wire

//--- logic/internet_checksum.sv
`timescale 1ns/10ps
`default_nettype none

module internet_checksum
	import ip_bus_pkg::*;
(
	input  wire            clk,
	input  wire            rx_flag_rst,
	input  wire            load,    // Preset from din[15:0]
	input  wire            clear,
	input  wire            process, // Add both halves of din
	input  wire bus_word_t din,
	output logic [15:0]    sum,     // Folded running sum, doubles as accumulator
	output logic [15:0]    csum     // Complement of the sum
);

	logic [17:0] raw;      // Up to two carries out of three terms
	logic [16:0] part;
	logic [15:0] sum_next;

	always_comb begin
		raw  = {2'b00, sum} + {2'b00, din[31:16]} + {2'b00, din[15:0]};
		part = {1'b0, raw[15:0]} + {15'b0, raw[17:16]}; // First end-around carry
		if (clear)
			sum_next = '0;
		else if (load)
			sum_next = din[15:0];
		else if (process)
			sum_next = part[15:0] + {15'b0, part[16]}; // Cannot carry again
		else
			sum_next = sum;
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			sum  <= '0;
			csum <= 16'hFFFF;
		end else begin
			sum  <= sum_next;
			csum <= ~sum_next;
		end
	end

endmodule

`default_nettype wire

//--- logic/tcp_port_table.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_port_table
	import tcp_types_pkg::*;
(
	input  wire            clk,
	input  wire            rx_flag_rst,
	input  wire            open_en,   // Wins over close
	input  wire            close_en,
	input  wire port_num_t port_num,
	input  wire            check_en,
	input  wire port_num_t check_port,
	output logic           check_open // Valid the cycle after check_en, held
);

	localparam int ROW_W = $clog2(`TCP_PORT_BINS);
	localparam int WAY_W = $clog2(`TCP_PORT_WAYS);

	port_num_t        port_mem [`TCP_PORT_BINS][`TCP_PORT_WAYS];
	logic [ROW_W-1:0] row;
	logic [ROW_W-1:0] check_row;
	logic [WAY_W-1:0] free_way;
	logic             free_hit;
	logic             check_hit;

	assign row       = port_num[ROW_W-1:0];
	assign check_row = check_port[ROW_W-1:0];

	always_comb begin
		free_hit  = 1'b0;
		free_way  = '0;
		check_hit = 1'b0;
		// Walk down so the lowest empty way is the one left
		for (int w = `TCP_PORT_WAYS - 1; w >= 0; w--) begin
			if (port_mem[row][w] == '0) begin
				free_hit = 1'b1;
				free_way = WAY_W'(w);
			end
		end
		for (int w = 0; w < `TCP_PORT_WAYS; w++)
			if (port_mem[check_row][w] == check_port)
				check_hit = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			for (int r = 0; r < `TCP_PORT_BINS; r++)
				for (int w = 0; w < `TCP_PORT_WAYS; w++)
					port_mem[r][w] <= '0;
			check_open <= 1'b0;
		end else begin
			if (open_en) begin
				if (free_hit) // Full row drops the open
					port_mem[row][free_way] <= port_num;
			end else if (close_en) begin
				for (int w = 0; w < `TCP_PORT_WAYS; w++)
					if (port_mem[row][w] == port_num)
						port_mem[row][w] <= '0; // Every copy goes
			end
			if (check_en)
				check_open <= check_hit && (check_port != '0); // Port 0 hits empty ways
		end
	end

endmodule

`default_nettype wire

//--- logic/tcp_rx_parser.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_rx_parser
	import ip_bus_pkg::*;
	import tcp_types_pkg::*;
(
	input  wire               clk,
	input  wire               rx_flag_rst,
	input  wire               rx_start,
	input  wire len16_t       rx_payload_len,
	input  wire               rx_protocol_is_tcp,
	input  wire ipv4_addr_t   rx_src_ip,
	input  wire               rx_data_valid,
	input  wire bytes_valid_t rx_bytes_valid,
	input  wire bus_word_t    rx_data,
	input  wire               rx_commit,
	input  wire               rx_drop,
	output logic              check_en,   // Port lookup during word 0
	output port_num_t         check_port,
	input  wire               check_open,
	input  wire               csum_ok,    // Sum of pseudo-header and words is 0xFFFF
	output logic              event_wr,
	output tcp_event_t        event_data
);

	rx_state_t   rx_state;
	ipv4_addr_t  src_ip;
	port_num_t   src_port;
	port_num_t   dst_port;
	logic [31:0] seq_num;
	logic [3:0]  data_offset;
	logic        flag_ack;
	logic        flag_syn;
	logic        word_ok;
	logic        word_bad;
	logic        accept;
	tcp_flags_t  reply_flags;

	assign word_ok  = rx_data_valid && (rx_bytes_valid == 3'd4);
	assign word_bad = rx_data_valid && (rx_bytes_valid != 3'd4); // Truncated segment

	assign check_en   = (rx_state == RX_PORTS) && word_ok;
	assign check_port = rx_data[15:0]; // Destination port

	// Bare SYN with a good checksum and no options
	assign accept = csum_ok && flag_syn && !flag_ack &&
		(data_offset == 4'(`TCP_HEADER_WORDS));

	// Open port answers SYN+ACK, closed port RST+ACK
	assign reply_flags = '{ack: 1'b1, rst: !check_open, syn: check_open, fin: 1'b0};

	////////////////////////////////////////////////////////////
	// Header walk

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			rx_state <= RX_IDLE;
			event_wr <= 1'b0;
		end else begin
			event_wr <= 1'b0;
			case (rx_state)
				RX_IDLE:
					if (rx_start && rx_protocol_is_tcp &&
						rx_payload_len == len16_t'(`TCP_HEADER_BYTES))
						rx_state <= RX_PORTS;
				RX_PORTS:  if (word_ok) rx_state <= RX_SEQ;
				RX_SEQ:    if (word_ok) rx_state <= RX_ACK;
				RX_ACK:    if (word_ok) rx_state <= RX_FLAGS;  // Their ack is not needed
				RX_FLAGS:  if (word_ok) rx_state <= RX_CSUM;
				RX_CSUM:   if (word_ok) rx_state <= RX_COMMIT; // Checksum, urgent pointer
				RX_COMMIT: if (rx_commit) event_wr <= accept && !rx_drop;
				default:   rx_state <= RX_IDLE;
			endcase
			// Short word, abort or end of segment
			if (rx_state != RX_IDLE && (word_bad || rx_drop || rx_commit))
				rx_state <= RX_IDLE;
		end
	end

	////////////////////////////////////////////////////////////
	// Field capture and reply

	always_ff @(posedge clk) begin
		if (rx_state == RX_IDLE && rx_start)
			src_ip <= rx_src_ip;
		if (rx_state == RX_PORTS && word_ok) begin
			src_port <= rx_data[31:16];
			dst_port <= rx_data[15:0];
		end
		if (rx_state == RX_SEQ && word_ok)
			seq_num <= rx_data;
		if (rx_state == RX_FLAGS && word_ok) begin
			data_offset <= rx_data[31:28];
			flag_ack    <= rx_data[20];
			flag_syn    <= rx_data[17];
		end
		if (rx_state == RX_COMMIT && rx_commit) begin
			event_data.remote_ip   <= src_ip;
			event_data.remote_port <= src_port;
			event_data.our_port    <= dst_port;
			event_data.flags       <= reply_flags;
			event_data.seq         <= `TCP_ISN;
			event_data.ack         <= seq_num + 32'd1; // SYN takes one number
		end
	end

endmodule

`default_nettype wire

//--- logic/tcp_event_fifo.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_event_fifo
	import tcp_types_pkg::*;
(
	input  wire             clk,
	input  wire             rx_flag_rst,
	input  wire             wr,    // Lost when full, the peer retries its SYN
	input  wire tcp_event_t din,
	input  wire             rd,
	output tcp_event_t      dout,  // Valid the cycle after rd
	output logic            empty
);

	localparam int PTR_W = $clog2(`TCP_EVENT_DEPTH);

	tcp_event_t   mem [`TCP_EVENT_DEPTH];
	logic [PTR_W:0] wr_ptr; // Extra bit tells full from empty
	logic [PTR_W:0] rd_ptr;
	logic           full;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr && !full)
			mem[wr_ptr[PTR_W-1:0]] <= din;
		if (rd && !empty)
			dout <= mem[rd_ptr[PTR_W-1:0]];
	end

endmodule

`default_nettype wire

//--- logic/tcp_tx_segmenter.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_tx_segmenter
	import ip_bus_pkg::*;
	import tcp_types_pkg::*;
(
	input  wire             clk,
	input  wire             rx_flag_rst,
	input  wire ipv4_addr_t local_ip,
	input  wire             ev_empty,
	output logic            ev_rd,
	input  wire tcp_event_t ev_data,
	output logic            ck_clear,
	output logic            ck_process,
	output bus_word_t       ck_din,
	input  wire [15:0]      ck_csum,
	input  wire             tx_credit,  // One segment slot back per cycle high
	output logic            tx_start,
	output ipv4_addr_t      tx_dst_ip,
	output logic            tx_data_valid,
	output bus_word_t       tx_data,
	output logic            tx_commit
);

	localparam int CREDIT_W = $clog2(`TCP_TX_CREDITS + 1);

	tx_state_t           tx_state;
	logic [CREDIT_W-1:0] credit_cnt;
	logic [2:0]          word_cnt;   // Pseudo, header and output word index
	ipv4_addr_t          remote_ip;
	bus_word_t           hdr_word [`TCP_HEADER_WORDS-1]; // Words 0 to 3
	logic                take_credit;

	assign ev_rd       = (tx_state == TX_IDLE) && !ev_empty && (credit_cnt != '0);
	assign take_credit = (tx_state == TX_CSUM); // Same edge that raises tx_start
	assign ck_clear    = (tx_state == TX_POP);
	assign ck_process  = (tx_state == TX_PSEUDO) || (tx_state == TX_HDR);

	always_comb begin
		ck_din = hdr_word[word_cnt[1:0]];
		if (tx_state == TX_PSEUDO) begin
			case (word_cnt)
				3'd0:    ck_din = remote_ip;
				3'd1:    ck_din = local_ip;
				default: ck_din = {8'h00, `IP_PROTO_TCP, 16'(`TCP_HEADER_BYTES)};
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_flag_rst)
			credit_cnt <= CREDIT_W'(`TCP_TX_CREDITS);
		else if (take_credit && !tx_credit)
			credit_cnt <= credit_cnt - 1'b1;
		else if (tx_credit && !take_credit)
			credit_cnt <= credit_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Segment FSM

	always_ff @(posedge clk) begin
		if (rx_flag_rst) begin
			tx_state      <= TX_IDLE;
			word_cnt      <= '0;
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_commit     <= 1'b0;
		end else begin
			tx_start      <= 1'b0;
			tx_data_valid <= 1'b0;
			tx_commit     <= 1'b0;
			case (tx_state)
				TX_IDLE: if (ev_rd) tx_state <= TX_POP;
				TX_POP: begin // Event out of the FIFO now
					word_cnt <= '0;
					tx_state <= TX_PSEUDO;
				end
				TX_PSEUDO: begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == 3'd2) begin
						word_cnt <= '0;
						tx_state <= TX_HDR;
					end
				end
				TX_HDR: begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == 3'(`TCP_HEADER_WORDS - 2)) begin
						word_cnt <= '0;
						tx_state <= TX_CSUM;
					end
				end
				TX_CSUM: begin // Fold settles here
					tx_start <= 1'b1;
					tx_state <= TX_DATA;
				end
				TX_DATA: begin
					tx_data_valid <= 1'b1;
					word_cnt      <= word_cnt + 1'b1;
					if (word_cnt == 3'(`TCP_HEADER_WORDS - 1))
						tx_state <= TX_COMMIT;
				end
				TX_COMMIT: begin
					tx_commit <= 1'b1;
					tx_state  <= TX_IDLE;
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_state == TX_POP) begin
			remote_ip   <= ev_data.remote_ip;
			hdr_word[0] <= {ev_data.our_port, ev_data.remote_port};
			hdr_word[1] <= ev_data.seq;
			hdr_word[2] <= ev_data.ack;
			hdr_word[3] <= {4'(`TCP_HEADER_WORDS), 7'h00, ev_data.flags.ack,
				1'b0, ev_data.flags.rst, ev_data.flags.syn, ev_data.flags.fin,
				16'(`TCP_WINDOW)}; // PSH stays clear
		end
		if (tx_state == TX_CSUM)
			tx_dst_ip <= remote_ip;
		if (tx_state == TX_DATA)
			tx_data <= (word_cnt == 3'(`TCP_HEADER_WORDS - 1)) ?
				{ck_csum, 16'h0000} : hdr_word[word_cnt[1:0]]; // Urgent pointer zero
	end

endmodule

`default_nettype wire

//--- logic/tcp_responder_top.sv
`timescale 1ns/10ps
`default_nettype none

module tcp_responder_top
	import ip_bus_pkg::*;
	import tcp_types_pkg::*;
(
	input  wire               clk,
	input  wire               rx_flag_rst,
	input  wire ipv4_addr_t   local_ip,
	input  wire               port_open_en,
	input  wire               port_close_en,
	input  wire port_num_t    port_num,
	input  wire               rx_start,
	input  wire len16_t       rx_payload_len,
	input  wire               rx_protocol_is_tcp,
	input  wire ipv4_addr_t   rx_src_ip,
	input  wire [15:0]        rx_pseudo_csum,
	input  wire               rx_data_valid,
	input  wire bytes_valid_t rx_bytes_valid,
	input  wire bus_word_t    rx_data,
	input  wire               rx_commit,
	input  wire               rx_drop,
	input  wire               tx_credit,
	output logic              tx_start,
	output ipv4_addr_t        tx_dst_ip,
	output logic              tx_data_valid,
	output bus_word_t         tx_data,
	output logic              tx_commit
);

	logic        check_en;
	port_num_t   check_port;
	logic        check_open;
	bus_word_t   rx_ck_din;
	logic [15:0] rx_ck_sum;
	logic        rx_csum_ok;
	logic        event_wr;
	tcp_event_t  event_data;
	logic        ev_rd;
	logic        ev_empty;
	tcp_event_t  ev_data;
	logic        ck_clear;
	logic        ck_process;
	bus_word_t   ck_din;
	logic [15:0] ck_csum;

	// Pseudo-header sum rides in at rx_start, then the segment words
	assign rx_ck_din  = rx_data_valid ? rx_data : {16'h0000, rx_pseudo_csum};
	assign rx_csum_ok = (rx_ck_sum == 16'hFFFF);

	tcp_port_table port_table_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.open_en(port_open_en), .close_en(port_close_en), .port_num(port_num),
		.check_en(check_en), .check_port(check_port), .check_open(check_open)
	);

	internet_checksum rx_csum_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.load(rx_start), .clear(rx_drop), .process(rx_data_valid), .din(rx_ck_din),
		.sum(rx_ck_sum), .csum()
	);

	tcp_rx_parser rx_parser_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.rx_start(rx_start), .rx_payload_len(rx_payload_len),
		.rx_protocol_is_tcp(rx_protocol_is_tcp), .rx_src_ip(rx_src_ip),
		.rx_data_valid(rx_data_valid), .rx_bytes_valid(rx_bytes_valid), .rx_data(rx_data),
		.rx_commit(rx_commit), .rx_drop(rx_drop),
		.check_en(check_en), .check_port(check_port), .check_open(check_open),
		.csum_ok(rx_csum_ok), .event_wr(event_wr), .event_data(event_data)
	);

	tcp_event_fifo event_fifo_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.wr(event_wr), .din(event_data), .rd(ev_rd), .dout(ev_data), .empty(ev_empty)
	);

	internet_checksum tx_csum_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst),
		.load(1'b0), .clear(ck_clear), .process(ck_process), .din(ck_din),
		.sum(), .csum(ck_csum)
	);

	tcp_tx_segmenter tx_segmenter_inst (
		.clk(clk), .rx_flag_rst(rx_flag_rst), .local_ip(local_ip),
		.ev_empty(ev_empty), .ev_rd(ev_rd), .ev_data(ev_data),
		.ck_clear(ck_clear), .ck_process(ck_process), .ck_din(ck_din), .ck_csum(ck_csum),
		.tx_credit(tx_credit), .tx_start(tx_start), .tx_dst_ip(tx_dst_ip),
		.tx_data_valid(tx_data_valid), .tx_data(tx_data), .tx_commit(tx_commit)
	);

endmodule

`default_nettype wire

//--- sim/tcp_tx_properties.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_tx_properties (
	input wire                                     clk,
	input wire                                     rx_flag_rst,
	input wire [$clog2(`TCP_TX_CREDITS + 1)-1:0]   credit_cnt,
	input wire                                     tx_start,
	input wire                                     tx_data_valid,
	input wire                                     tx_commit
);

	// Count seen in TX_CSUM, before the launch edge took one
	credit_held: assert property (@(posedge clk) disable iff (rx_flag_rst)
		tx_start |-> $past(credit_cnt) != '0)
		else $error("tx_start raised with no credit left");

	start_not_data: assert property (@(posedge clk) disable iff (rx_flag_rst)
		!(tx_start && tx_data_valid))
		else $error("tx_start and tx_data_valid high together");

	// Start, five words, commit
	framing: assert property (@(posedge clk) disable iff (rx_flag_rst)
		tx_start |=> tx_data_valid [*5] ##1 tx_commit)
		else $error("segment not framed as five words then commit");

	quiet_in_reset: assert property (@(posedge clk)
		rx_flag_rst |=> !tx_start && !tx_data_valid && !tx_commit)
		else $error("transmit outputs active during reset");

endmodule

bind tcp_tx_segmenter tcp_tx_properties tx_properties_inst (
	.clk(clk), .rx_flag_rst(rx_flag_rst), .credit_cnt(credit_cnt),
	.tx_start(tx_start), .tx_data_valid(tx_data_valid), .tx_commit(tx_commit)
);

`default_nettype wire

//--- sim/tcp_responder_tb.sv
`timescale 1ns/10ps
`include "tcp_cfg.svh"
`default_nettype none

module tcp_responder_tb
	import ip_bus_pkg::*;
	import tcp_types_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int SEG_TOTAL  = 21;   // Inbound segments over all tests
	localparam int SEG_BOUND  = 60;   // Cycles per segment with reply and credit
	localparam int MARGIN     = 400;
	localparam logic [31:0] REPLY_ISN    = 32'h0EADBEEF;
	localparam logic [15:0] REPLY_WINDOW = 16'd1024;
	// Ways to spoil an inbound segment
	localparam int F_NONE  = 0;
	localparam int F_CSUM  = 1;
	localparam int F_LEN   = 2;
	localparam int F_SHORT = 3;
	localparam int F_DROP  = 4;
	localparam int F_PROTO = 5;

	typedef struct packed {
		ipv4_addr_t       dst;
		logic [4:0][31:0] words;
	} reply_t;

	logic clk = 1'b0;
	logic rx_flag_rst, port_open_en, port_close_en, tx_credit;
	logic rx_start, rx_protocol_is_tcp, rx_data_valid, rx_commit, rx_drop;
	logic tx_start, tx_data_valid, tx_commit;
	ipv4_addr_t   local_ip, rx_src_ip, tx_dst_ip;
	port_num_t    port_num;
	len16_t       rx_payload_len;
	logic [15:0]  rx_pseudo_csum;
	bytes_valid_t rx_bytes_valid;
	bus_word_t    rx_data, tx_data;

	reply_t exp_q [$];    // Replies owed with the oldest in front
	integer seed;
	int     errors, checks, tests_run, errors_before, seg_count, credits_owed, credit_wait;
	bit     hold_credits;
	string  test_name;

	tcp_responder_top tcp_responder_top_inst (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [15:0] fold_sum(input logic [31:0] s);
		s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
		s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]}; // Second carry at most
		return s[15:0];
	endfunction

	function automatic logic [31:0] add_word(input logic [31:0] s, input logic [31:0] w);
		return s + {16'h0000, w[31:16]} + {16'h0000, w[15:0]};
	endfunction

	// Reply to a bare SYN with its checksum over pseudo-header and words 0 to 3
	function automatic reply_t expected_reply(input ipv4_addr_t src, input port_num_t sport,
		input port_num_t dport, input logic [31:0] seq, input logic is_open);
		reply_t      r;
		logic [31:0] s;
		r.dst      = src;
		r.words[0] = {dport, sport};   // Ports swapped
		r.words[1] = REPLY_ISN;
		r.words[2] = seq + 32'd1;
		r.words[3] = {4'd5, 7'h00, 1'b1, 1'b0, !is_open, is_open, 1'b0, REPLY_WINDOW};
		s = add_word(add_word(add_word(32'd0, src), local_ip), 32'h0006_0014);
		for (int i = 0; i < 4; i++)
			s = add_word(s, r.words[i]);
		r.words[4] = {~fold_sum(s), 16'h0000};
		return r;
	endfunction

	function automatic port_num_t random_port();
		port_num_t p;
		p = $random(seed);
		if (p == '0)
			p = 16'h0001;   // Zero marks an empty entry
		return p;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic open_port(input port_num_t p);
		@(negedge clk);
		port_num     = p;
		port_open_en = 1'b1;
		@(negedge clk);
		port_open_en = 1'b0;
	endtask

	task automatic close_port(input port_num_t p);
		@(negedge clk);
		port_num      = p;
		port_close_en = 1'b1;
		@(negedge clk);
		port_close_en = 1'b0;
	endtask

	// One header-only segment that queues a reply only when it is a clean bare SYN
	task automatic send_segment(input ipv4_addr_t src, input port_num_t sport,
		input port_num_t dport, input logic [31:0] seq, input logic ack_bit,
		input logic syn_bit, input int fault, input logic is_open);
		logic [31:0] w [5];
		logic [31:0] s;
		logic [15:0] pseudo;
		w[0] = {sport, dport};
		w[1] = seq;
		w[2] = $random(seed);
		w[3] = {4'd5, 7'h00, ack_bit, 1'b0, 1'b0, syn_bit, 1'b0, 16'($random(seed))};
		pseudo = fold_sum(add_word(add_word(add_word(32'd0, src), local_ip), 32'h0006_0014));
		s = {16'h0000, pseudo};
		for (int i = 0; i < 4; i++)
			s = add_word(s, w[i]);
		w[4] = {~fold_sum(s), 16'h0000};   // Urgent pointer zero
		if (fault == F_CSUM)
			w[4][16] = ~w[4][16];
		@(negedge clk);
		rx_start           = 1'b1;
		rx_payload_len     = (fault == F_LEN) ? 16'd24 : 16'd20;
		rx_protocol_is_tcp = (fault != F_PROTO);
		rx_src_ip          = src;
		rx_pseudo_csum     = pseudo;
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			rx_start       = 1'b0;
			rx_data_valid  = 1'b1;
			rx_bytes_valid = (fault == F_SHORT && i == 2) ? 3'd3 : 3'd4;
			rx_data        = w[i];
		end
		@(negedge clk);
		rx_data_valid = 1'b0;
		rx_commit     = (fault != F_DROP);
		rx_drop       = (fault == F_DROP);
		if (fault == F_NONE && syn_bit && !ack_bit)
			exp_q.push_back(expected_reply(src, sport, dport, seq, is_open));
		@(negedge clk);
		rx_commit = 1'b0;
		rx_drop   = 1'b0;
	endtask

	task automatic drain_replies();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (30) @(negedge clk);   // Room for the last commit and any stray reply
	endtask

	task automatic start_test(input string name);
		test_name     = name;
		errors_before = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("%s finished, %0d errors", test_name, errors - errors_before);
	endtask

	////////////////////////////////////////////////////////////
	// Compare and credit return

	initial begin : reply_monitor
		reply_t cur;
		int     widx;
		bit     active;
		active = 1'b0;
		widx   = 0;
		forever begin
			@(negedge clk);   // Registered outputs settled
			tx_credit = 1'b0;
			if (tx_start) begin
				widx = 0;
				if (exp_q.size() == 0) begin
					errors++;
					active = 1'b0;
					$display("%s: a reply went out with no valid SYN waiting for it", test_name);
				end else begin
					cur    = exp_q.pop_front();
					active = 1'b1;
					check_value("tx_dst_ip", cur.dst, tx_dst_ip);
				end
			end
			if (tx_data_valid) begin
				if (active && widx < 5)
					check_value($sformatf("word %0d", widx), cur.words[widx], tx_data);
				widx++;
			end
			if (tx_commit) begin
				check_value("word count", 32'd5, widx);
				seg_count++;
				credits_owed++;
			end
			if (!hold_credits && credits_owed > 0) begin
				if (credit_wait == 3) begin   // IP layer frees the slot a bit later
					tx_credit = 1'b1;
					credits_owed--;
					credit_wait = 0;
				end else begin
					credit_wait++;
				end
			end
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * (SEG_TOTAL * SEG_BOUND + MARGIN));
		$display("Watchdog expired, the run hung waiting for replies");
		$display("*** TEST FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Tests

	initial begin : stimulus
		ipv4_addr_t  src;
		port_num_t   sp, dp;
		port_num_t   row_ports [5];
		logic [31:0] seq;
		logic [7:0]  low;
		int          base;
		seed = 83;
		errors = 0;
		checks = 0;
		tests_run = 0;
		seg_count = 0;
		credits_owed = 0;
		credit_wait = 0;
		hold_credits = 1'b0;
		rx_flag_rst = 1'b1;
		port_open_en = 1'b0;
		port_close_en = 1'b0;
		port_num = '0;
		rx_start = 1'b0;
		rx_payload_len = '0;
		rx_protocol_is_tcp = 1'b0;
		rx_src_ip = '0;
		rx_pseudo_csum = '0;
		rx_data_valid = 1'b0;
		rx_bytes_valid = 3'd4;
		rx_data = '0;
		rx_commit = 1'b0;
		rx_drop = 1'b0;
		tx_credit = 1'b0;
		local_ip = $random(seed);
		repeat (3) @(negedge clk);
		rx_flag_rst = 1'b0;

		start_test("closed_port_rst");
		send_segment($random(seed), random_port(), random_port(), $random(seed),
			1'b0, 1'b1, F_NONE, 1'b0);
		drain_replies();
		end_test();

		start_test("open_then_close");
		src = $random(seed);
		sp  = random_port();
		dp  = random_port();
		seq = $random(seed);
		open_port(dp);
		send_segment(src, sp, dp, seq, 1'b0, 1'b1, F_NONE, 1'b1);
		drain_replies();
		close_port(dp);
		send_segment(src, sp, dp, seq, 1'b0, 1'b1, F_NONE, 1'b0);
		drain_replies();
		end_test();

		start_test("full_row");
		low = $random(seed);
		for (int i = 0; i < 5; i++) begin
			row_ports[i] = {8'(i * 37 + 1), low};   // Same row so the fifth one overflows
			open_port(row_ports[i]);
		end
		for (int i = 0; i < 5; i++)
			send_segment($random(seed), random_port(), row_ports[i], $random(seed),
				1'b0, 1'b1, F_NONE, (i < 4));
		drain_replies();
		end_test();

		start_test("ignored_segments");
		for (int f = F_CSUM; f <= F_PROTO; f++)
			send_segment($random(seed), random_port(), random_port(), $random(seed),
				1'b0, 1'b1, f, 1'b0);
		send_segment($random(seed), random_port(), random_port(), $random(seed),
			1'b1, 1'b1, F_NONE, 1'b0);   // SYN with ACK
		send_segment($random(seed), random_port(), random_port(), $random(seed),
			1'b0, 1'b0, F_NONE, 1'b0);   // No SYN
		send_segment($random(seed), random_port(), random_port(), $random(seed),
			1'b0, 1'b1, F_NONE, 1'b0);
		drain_replies();
		end_test();

		start_test("credit_backpressure");
		hold_credits = 1'b1;
		base = seg_count;
		for (int i = 0; i < 5; i++)
			send_segment($random(seed), random_port(), random_port(), $random(seed),
				1'b0, 1'b1, F_NONE, 1'b0);
		while (seg_count - base < `TCP_TX_CREDITS)
			@(negedge clk);
		repeat (80) @(negedge clk);   // Nothing more may leave
		check_value("segments without credit", `TCP_TX_CREDITS, seg_count - base);
		hold_credits = 1'b0;
		drain_replies();
		check_value("segments after release", 32'd5, seg_count - base);
		end_test();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/ip_bus_pkg.sv
logic/tcp_types_pkg.sv
logic/internet_checksum.sv
logic/tcp_port_table.sv
logic/tcp_rx_parser.sv
logic/tcp_event_fifo.sv
logic/tcp_tx_segmenter.sv
logic/tcp_responder_top.sv
sim/tcp_tx_properties.sv
sim/tcp_responder_tb.sv

//--- Bender.yml
package:
  name: tcp_responder

sources:
  - include_dirs:
      - logic
    files:
      - logic/ip_bus_pkg.sv
      - logic/tcp_types_pkg.sv
      - logic/internet_checksum.sv
      - logic/tcp_port_table.sv
      - logic/tcp_rx_parser.sv
      - logic/tcp_event_fifo.sv
      - logic/tcp_tx_segmenter.sv
      - logic/tcp_responder_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tcp_tx_properties.sv
      - sim/tcp_responder_tb.sv
